// File: src/csr_pkg.sv
// CSR bus package: Wishbone and CSR bus structs, register maps, bus widths

package csr_pkg;

	// ------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------

	// CSR word address, taken from Wishbone address bits 15:2
	localparam int CSR_AW = 14;
	// Bank field in the top bits of the CSR address
	localparam int BANK_W = 4;
	// Register index below the bank field
	localparam int REG_W = CSR_AW - BANK_W;

	typedef logic [31:0] csr_data_t;

	// ------------------------------------------------------------
	// Bus structs
	// ------------------------------------------------------------

	// Wishbone classic request, master to slave
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	// Wishbone classic response, slave to master
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// CSR request, we is a single-cycle strobe
	typedef struct packed {
		logic [CSR_AW-1:0] adr;
		logic              we;
		csr_data_t         dat;
	} csr_req_t;

	// ------------------------------------------------------------
	// Encodings
	// ------------------------------------------------------------

	// Bridge FSM
	typedef enum logic [1:0] {
		BRG_IDLE = 2'd0,
		BRG_READ = 2'd1,
		BRG_ACK  = 2'd2
	} brg_state_e;

	// GPIO bank register map
	typedef enum logic [REG_W-1:0] {
		GPIO_ID       = 10'd0,
		GPIO_IN       = 10'd1,
		GPIO_OUT      = 10'd2,
		GPIO_IRQ_EN   = 10'd3,
		GPIO_IRQ_PEND = 10'd4
	} gpio_reg_e;

	// Timer bank register map
	typedef enum logic [REG_W-1:0] {
		TMR_CTRL    = 10'd0,
		TMR_COMPARE = 10'd1,
		TMR_COUNT   = 10'd2,
		TMR_STATUS  = 10'd3
	} timer_reg_e;

endpackage

// File: src/wb_csr_bridge.sv
// Wishbone classic to CSR bridge with a fixed two-cycle ack and OR-combined read data
`timescale 1ns/1ns

module wb_csr_bridge (
	input  logic               sys_clk,
	input  logic               rst1,
	input  csr_pkg::wb_req_t   wb_req_i,
	output csr_pkg::wb_rsp_t   wb_rsp_o,
	output csr_pkg::csr_req_t  csr_req_o,
	input  csr_pkg::csr_data_t gpio_dr_i,
	input  csr_pkg::csr_data_t timer_dr_i
);
	import csr_pkg::*;

	brg_state_e state;

	// Registered CSR request fields
	logic [CSR_AW-1:0] req_adr;
	logic              req_we;
	csr_data_t         req_dat;

	// New access sampled this edge
	logic start;

	// Only sampled while idle, so a strobe held across ack is ignored
	assign start = (state == BRG_IDLE) && wb_req_i.cyc && wb_req_i.stb;

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	// IDLE -> READ -> ACK -> IDLE, never waits
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			state <= BRG_IDLE;
		end else begin
			case (state)
				BRG_IDLE: begin
					if (start) begin
						state <= BRG_READ;
					end
				end
				// Peripherals register their read words here
				BRG_READ: state <= BRG_ACK;
				BRG_ACK:  state <= BRG_IDLE;
				default:  state <= BRG_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// CSR request
	// ------------------------------------------------------------

	// Write strobe lasts one cycle, the READ cycle
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			req_we <= 1'b0;
		end else begin
			req_we <= start && wb_req_i.we;
		end
	end

	// Address and data latched at the start of each access
	always_ff @(posedge sys_clk) begin
		if (start) begin
			// Word address, byte offset dropped
			req_adr <= wb_req_i.adr[CSR_AW+1:2];
			req_dat <= wb_req_i.dat;
		end
	end

	assign csr_req_o.adr = req_adr;
	assign csr_req_o.we  = req_we;
	assign csr_req_o.dat = req_dat;

	// ------------------------------------------------------------
	// Wishbone response
	// ------------------------------------------------------------

	// Unselected peripherals return zero, so OR is the read mux
	assign wb_rsp_o.dat = gpio_dr_i | timer_dr_i;
	// One-cycle ack
	assign wb_rsp_o.ack = (state == BRG_ACK);

endmodule

// File: src/gpio_ctl.sv
// System and GPIO controller: system ID, synchronized inputs with change interrupts, outputs
`timescale 1ns/1ns

module gpio_ctl #(
	parameter logic [csr_pkg::BANK_W-1:0] csr_bank  = 4'd1,
	parameter logic [31:0]                system_id = 32'h0,
	parameter int                         n_gpio    = 4
) (
	input  logic               sys_clk,
	input  logic               rst1,
	input  csr_pkg::csr_req_t  csr_req_i,
	output csr_pkg::csr_data_t csr_dr_o,
	input  logic [n_gpio-1:0]  gpio_i,
	output logic [n_gpio-1:0]  gpio_o,
	output logic               irq_o
);
	import csr_pkg::*;

	// Address decode
	logic      sel;
	logic      wr;
	gpio_reg_e reg_idx;

	// Input synchronizer and edge detect
	logic [n_gpio-1:0] in_meta;
	logic [n_gpio-1:0] in_sync;
	logic [n_gpio-1:0] in_prev;

	// Control registers
	logic [n_gpio-1:0] out_q;
	logic [n_gpio-1:0] irq_en;
	logic [n_gpio-1:0] pend;
	logic              irq_q;

	csr_data_t dr_q;
	csr_data_t rd_word;

	assign sel     = (csr_req_i.adr[CSR_AW-1 -: BANK_W] == csr_bank);
	assign wr      = sel && csr_req_i.we;
	assign reg_idx = gpio_reg_e'(csr_req_i.adr[REG_W-1:0]);

	// ------------------------------------------------------------
	// Input pins
	// ------------------------------------------------------------

	// Two-stage synchronizer, runs during reset so no false change on release
	always_ff @(posedge sys_clk) begin
		in_meta <= gpio_i;
		in_sync <= in_meta;
		in_prev <= in_sync;
	end

	// ------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			out_q  <= '0;
			irq_en <= '0;
			pend   <= '0;
			irq_q  <= 1'b0;
		end else begin
			// Any change sets pending; set wins over a clear in the same cycle
			if (wr && reg_idx == GPIO_IRQ_PEND) begin
				pend <= (pend & ~csr_req_i.dat[n_gpio-1:0]) | (in_sync ^ in_prev);
			end else begin
				pend <= pend | (in_sync ^ in_prev);
			end
			if (wr && reg_idx == GPIO_OUT) begin
				out_q <= csr_req_i.dat[n_gpio-1:0];
			end
			if (wr && reg_idx == GPIO_IRQ_EN) begin
				irq_en <= csr_req_i.dat[n_gpio-1:0];
			end
			// Registered, one cycle behind pending
			irq_q <= |(pend & irq_en);
		end
	end

	// ------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------

	// Pin-wide fields zero-extend, upper bits read zero
	always_comb begin
		case (reg_idx)
			GPIO_ID:       rd_word = system_id;
			GPIO_IN:       rd_word = 32'(in_sync);
			GPIO_OUT:      rd_word = 32'(out_q);
			GPIO_IRQ_EN:   rd_word = 32'(irq_en);
			GPIO_IRQ_PEND: rd_word = 32'(pend);
			default:       rd_word = '0;
		endcase
	end

	// Zero outside our bank so the bridge can OR
	always_ff @(posedge sys_clk) begin
		dr_q <= sel ? rd_word : '0;
	end

	assign csr_dr_o = dr_q;
	assign gpio_o   = out_q;
	assign irq_o    = irq_q;

endmodule

// File: src/timer_ctl.sv
// Timer with compare match, one-shot or auto-reload mode, and an interrupt
`timescale 1ns/1ns

module timer_ctl #(
	parameter logic [csr_pkg::BANK_W-1:0] csr_bank = 4'd2
) (
	input  logic               sys_clk,
	input  logic               rst1,
	input  csr_pkg::csr_req_t  csr_req_i,
	output csr_pkg::csr_data_t csr_dr_o,
	output logic               irq_o
);
	import csr_pkg::*;

	// Address decode
	logic       sel;
	logic       wr;
	timer_reg_e reg_idx;

	// TMR_CTRL bits
	logic en;
	logic auto_reload;
	logic irq_en;

	logic [31:0] compare;
	logic [31:0] count;
	logic        expired;
	logic        irq_q;

	// Count has reached the compare value
	logic match;

	csr_data_t dr_q;
	csr_data_t rd_word;

	assign sel     = (csr_req_i.adr[CSR_AW-1 -: BANK_W] == csr_bank);
	assign wr      = sel && csr_req_i.we;
	assign reg_idx = timer_reg_e'(csr_req_i.adr[REG_W-1:0]);
	assign match   = en && (count == compare);

	// ------------------------------------------------------------
	// Counter and registers
	// ------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			en          <= 1'b0;
			auto_reload <= 1'b0;
			irq_en      <= 1'b0;
			compare     <= '0;
			count       <= '0;
			expired     <= 1'b0;
			irq_q       <= 1'b0;
		end else begin
			// Counting
			if (match) begin
				expired <= 1'b1;
				if (auto_reload) begin
					count <= '0;
				end else begin
					// One-shot stops, count holds at compare
					en <= 1'b0;
				end
			end else if (en) begin
				count <= count + 32'd1;
			end

			// CSR writes come last and take priority
			if (wr) begin
				case (reg_idx)
					TMR_CTRL: begin
						en          <= csr_req_i.dat[0];
						auto_reload <= csr_req_i.dat[1];
						irq_en      <= csr_req_i.dat[2];
					end
					TMR_COMPARE: compare <= csr_req_i.dat;
					TMR_COUNT:   count   <= csr_req_i.dat;
					TMR_STATUS: begin
						// Write one to clear
						if (csr_req_i.dat[0]) begin
							expired <= 1'b0;
						end
					end
					default: ;
				endcase
			end

			irq_q <= expired && irq_en;
		end
	end

	// ------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------

	always_comb begin
		case (reg_idx)
			TMR_CTRL:    rd_word = {29'd0, irq_en, auto_reload, en};
			TMR_COMPARE: rd_word = compare;
			TMR_COUNT:   rd_word = count;
			TMR_STATUS:  rd_word = {31'd0, expired};
			default:     rd_word = '0;
		endcase
	end

	// Zero outside our bank
	always_ff @(posedge sys_clk) begin
		dr_q <= sel ? rd_word : '0;
	end

	assign csr_dr_o = dr_q;
	assign irq_o    = irq_q;

endmodule

// File: src/periph_top.sv
// Peripheral subsystem: Wishbone to CSR bridge with GPIO and timer controllers
`timescale 1ns/1ns

module periph_top #(
	parameter logic [csr_pkg::BANK_W-1:0] GPIO_BANK  = 4'd1,
	parameter logic [csr_pkg::BANK_W-1:0] TIMER_BANK = 4'd2,
	parameter logic [31:0]                SYSTEM_ID  = 32'h53334145,
	parameter int                         N_GPIO     = 4
) (
	input  logic              sys_clk,
	input  logic              rst1,
	input  csr_pkg::wb_req_t  wb_req_i,
	output csr_pkg::wb_rsp_t  wb_rsp_o,
	input  logic [N_GPIO-1:0] gpio_i,
	output logic [N_GPIO-1:0] gpio_o,
	output logic              gpio_irq_o,
	output logic              timer_irq_o
);
	import csr_pkg::*;

	// ------------------------------------------------------------
	// CSR bus
	// ------------------------------------------------------------

	// Shared request, one read word per peripheral
	csr_req_t  csr_req;
	csr_data_t gpio_dr;
	csr_data_t timer_dr;

	// ------------------------------------------------------------
	// Bridge
	// ------------------------------------------------------------

	wb_csr_bridge u_bridge (
		.sys_clk    (sys_clk),
		.rst1       (rst1),
		.wb_req_i   (wb_req_i),
		.wb_rsp_o   (wb_rsp_o),
		.csr_req_o  (csr_req),
		.gpio_dr_i  (gpio_dr),
		.timer_dr_i (timer_dr)
	);

	// ------------------------------------------------------------
	// Peripherals
	// ------------------------------------------------------------

	// System ID and GPIO
	gpio_ctl #(
		.csr_bank  (GPIO_BANK),
		.system_id (SYSTEM_ID),
		.n_gpio    (N_GPIO)
	) u_gpio (
		.sys_clk   (sys_clk),
		.rst1      (rst1),
		.csr_req_i (csr_req),
		.csr_dr_o  (gpio_dr),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.irq_o     (gpio_irq_o)
	);

	// Compare timer
	timer_ctl #(
		.csr_bank  (TIMER_BANK)
	) u_timer (
		.sys_clk   (sys_clk),
		.rst1      (rst1),
		.csr_req_i (csr_req),
		.csr_dr_o  (timer_dr),
		.irq_o     (timer_irq_o)
	);

endmodule

// File: dv/tb_periph_top.sv
// Testbench for the peripheral subsystem: random Wishbone traffic checked against a register model
`timescale 1ns/1ns

module tb_periph_top;
	import csr_pkg::*;

	// Expected DUT configuration, periph_top defaults
	localparam logic [BANK_W-1:0] GPIO_BANK  = 4'd1;
	localparam logic [BANK_W-1:0] TIMER_BANK = 4'd2;
	localparam logic [31:0]       SYSTEM_ID  = 32'h53334145;
	localparam int                N_GPIO     = 4;

	// Test sizes
	localparam int N_DECODE  = 16;
	localparam int N_OUT     = 16;
	localparam int N_PIN     = 12;
	localparam int N_MIX     = 40;
	localparam int PIN_WAIT  = 5;
	localparam int MAX_CMP   = 23;
	localparam int ACK_LIMIT = 8;

	// Bus accesses per test, in test order
	localparam int N_ACCESS    = (1 + N_DECODE) + 2 * N_OUT + (1 + 4 * N_PIN) + 8 + 14
		+ (10 + N_MIX);
	localparam int TMR_WAIT    = 2 * MAX_CMP + 10;
	localparam int CYCLE_LIMIT = N_ACCESS * 4 + 2 * TMR_WAIT + N_PIN * PIN_WAIT + 100;

	logic              sys_clk;
	logic              rst1;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	logic [N_GPIO-1:0] gpio_in;
	logic [N_GPIO-1:0] gpio_out;
	logic              gpio_irq;
	logic              timer_irq;

	integer seed;
	int     n_checks;
	int     n_errors;
	int     n_tests;
	int     cycle_cnt;

	// Register model
	logic [N_GPIO-1:0] m_out;
	logic [N_GPIO-1:0] m_en;
	logic [N_GPIO-1:0] m_pend;
	logic [N_GPIO-1:0] m_pins;
	csr_data_t         m_ctrl;
	csr_data_t         m_cmp;
	csr_data_t         m_count;

	periph_top u_dut (
		.sys_clk     (sys_clk),
		.rst1        (rst1),
		.wb_req_i    (wb_req),
		.wb_rsp_o    (wb_rsp),
		.gpio_i      (gpio_in),
		.gpio_o      (gpio_out),
		.gpio_irq_o  (gpio_irq),
		.timer_irq_o (timer_irq)
	);

	// 10 ns clock
	always #5 sys_clk = ~sys_clk;

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Run stopped: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	function automatic csr_data_t rand_word();
		return $random(seed);
	endfunction

	// Byte address of a CSR, upper bits zero
	function automatic logic [31:0] reg_addr(input logic [BANK_W-1:0] bank,
		input logic [REG_W-1:0] idx);
		return {16'd0, bank, idx, 2'b00};
	endfunction

	task automatic check_word(input string what, input csr_data_t got, input csr_data_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	task automatic check_pins(input string what, input logic [N_GPIO-1:0] got,
		input logic [N_GPIO-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic check_irq(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// One Wishbone classic access, entered and left 1 ns after a rising edge
	task automatic wb_access(input logic [31:0] adr, input logic we, input csr_data_t wdat,
		output csr_data_t rdat);
		int   n;
		logic got;
		n = 0;
		got = 1'b0;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		wb_req.we  = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		while (!got && n < ACK_LIMIT) begin
			@(posedge sys_clk);
			#1;
			n++;
			got = wb_rsp.ack;
		end
		rdat = wb_rsp.dat;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
		n_checks++;
		if (!got) begin
			n_errors++;
			$display("Bus access to address 0x%08h got no ack within %0d cycles", adr, ACK_LIMIT);
		end else begin
			// Ack fixed at two cycles after stb is sampled
			if (n != 2) begin
				n_errors++;
				$display("Error at %0t: ack after %0d cycles, expected 2", $time, n);
			end
			@(posedge sys_clk);
			#1;
			if (wb_rsp.ack) begin
				n_errors++;
				$display("Error at %0t: ack held longer than one cycle", $time);
			end
		end
	endtask

	task automatic write_reg(input logic [BANK_W-1:0] bank, input logic [REG_W-1:0] idx,
		input csr_data_t dat);
		csr_data_t unused;
		wb_access(reg_addr(bank, idx), 1'b1, dat, unused);
	endtask

	task automatic read_reg(input logic [BANK_W-1:0] bank, input logic [REG_W-1:0] idx,
		output csr_data_t rdat);
		wb_access(reg_addr(bank, idx), 1'b0, '0, rdat);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	task automatic end_test(input string name, input int errs_before);
		n_tests++;
		$display("Test %0d (%s) finished with %0d errors", n_tests, name,
			n_errors - errs_before);
	endtask

	// Mixed traffic: 0 GPIO_OUT, 1 GPIO_IRQ_EN, 2 TMR_CTRL, 3 TMR_COMPARE, 4 TMR_COUNT
	function automatic logic [BANK_W-1:0] mix_bank(input int k);
		return (k < 2) ? GPIO_BANK : TIMER_BANK;
	endfunction

	function automatic logic [REG_W-1:0] mix_reg(input int k);
		case (k)
			0:       return GPIO_OUT;
			1:       return GPIO_IRQ_EN;
			2:       return TMR_CTRL;
			3:       return TMR_COMPARE;
			default: return TMR_COUNT;
		endcase
	endfunction

	function automatic csr_data_t mix_expect(input int k);
		case (k)
			0:       return 32'(m_out);
			1:       return 32'(m_en);
			2:       return m_ctrl;
			3:       return m_cmp;
			default: return m_count;
		endcase
	endfunction

	// Timer enable kept low so the counter holds still
	task automatic mix_write(input int k, input csr_data_t dat);
		csr_data_t val;
		val = (k == 2) ? (dat & 32'h6) : dat;
		case (k)
			0:       m_out = val[N_GPIO-1:0];
			1:       m_en = val[N_GPIO-1:0];
			2:       m_ctrl = val;
			3:       m_cmp = val;
			default: m_count = val;
		endcase
		write_reg(mix_bank(k), mix_reg(k), val);
		if (k == 0) begin
			check_pins("gpio_o", gpio_out, m_out);
		end
	endtask

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------

	initial begin
		csr_data_t         rd;
		csr_data_t         r;
		csr_data_t         cmp;
		int                errs;
		int                k;
		logic [BANK_W-1:0] bank;
		logic [N_GPIO-1:0] clr;

		seed = 32'ha3f20cf3;
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		cycle_cnt = 0;
		m_out = '0;
		m_en = '0;
		m_pend = '0;
		m_pins = '0;
		m_ctrl = '0;
		m_cmp = '0;
		m_count = '0;
		sys_clk = 1'b0;
		rst1 = 1'b1;
		wb_req = '0;
		gpio_in = '0;

		repeat (8) @(posedge sys_clk);
		#1;
		rst1 = 1'b0;
		check_pins("gpio_o after reset", gpio_out, '0);
		check_irq("gpio_irq_o after reset", gpio_irq, 1'b0);
		check_irq("timer_irq_o after reset", timer_irq, 1'b0);

		// Bus timing, system ID and unmapped banks
		errs = n_errors;
		read_reg(GPIO_BANK, GPIO_ID, rd);
		check_word("GPIO_ID", rd, SYSTEM_ID);
		for (int i = 0; i < N_DECODE; i++) begin
			r = rand_word();
			bank = r[15:12];
			if (bank == GPIO_BANK || bank == TIMER_BANK) begin
				bank = bank + 4'd3;
			end
			// Index walks the GPIO map so a missed bank decode returns the ID
			wb_access({r[31:16], bank, REG_W'(i % 5), 2'b00}, 1'b0, '0, rd);
			check_word("unmapped bank", rd, '0);
		end
		end_test("bus timing and decoding", errs);

		// GPIO outputs
		errs = n_errors;
		for (int i = 0; i < N_OUT; i++) begin
			r = rand_word();
			write_reg(GPIO_BANK, GPIO_OUT, r);
			m_out = r[N_GPIO-1:0];
			check_pins("gpio_o", gpio_out, m_out);
			read_reg(GPIO_BANK, GPIO_OUT, rd);
			check_word("GPIO_OUT", rd, 32'(m_out));
		end
		end_test("gpio outputs", errs);

		// GPIO inputs, pending bits and interrupt
		errs = n_errors;
		r = rand_word();
		m_en = r[N_GPIO-1:0];
		write_reg(GPIO_BANK, GPIO_IRQ_EN, r);
		for (int i = 0; i < N_PIN; i++) begin
			r = rand_word();
			m_pend = m_pend | (m_pins ^ r[N_GPIO-1:0]);
			m_pins = r[N_GPIO-1:0];
			gpio_in = m_pins;
			// Two sync stages, then pending, then the irq register
			wait_cycles(PIN_WAIT);
			check_irq("gpio_irq_o after pin change", gpio_irq, |(m_pend & m_en));
			read_reg(GPIO_BANK, GPIO_IN, rd);
			check_word("GPIO_IN", rd, 32'(m_pins));
			read_reg(GPIO_BANK, GPIO_IRQ_PEND, rd);
			check_word("GPIO_IRQ_PEND", rd, 32'(m_pend));
			r = rand_word();
			clr = r[N_GPIO-1:0];
			write_reg(GPIO_BANK, GPIO_IRQ_PEND, r);
			m_pend = m_pend & ~clr;
			check_irq("gpio_irq_o after clear", gpio_irq, |(m_pend & m_en));
			read_reg(GPIO_BANK, GPIO_IRQ_PEND, rd);
			check_word("GPIO_IRQ_PEND after clear", rd, 32'(m_pend));
		end
		end_test("gpio inputs and interrupts", errs);

		// Timer one-shot with interrupt
		errs = n_errors;
		r = rand_word();
		cmp = 32'd8 + 32'(r[3:0]);
		write_reg(TIMER_BANK, TMR_STATUS, 32'd1);
		write_reg(TIMER_BANK, TMR_COUNT, 32'd0);
		write_reg(TIMER_BANK, TMR_COMPARE, cmp);
		write_reg(TIMER_BANK, TMR_CTRL, 32'd5);
		wait_cycles(int'(cmp) + 10);
		read_reg(TIMER_BANK, TMR_STATUS, rd);
		check_word("TMR_STATUS one-shot", rd, 32'd1);
		// Enable cleared, interrupt enable kept
		read_reg(TIMER_BANK, TMR_CTRL, rd);
		check_word("TMR_CTRL one-shot", rd, 32'd4);
		read_reg(TIMER_BANK, TMR_COUNT, rd);
		check_word("TMR_COUNT one-shot", rd, cmp);
		check_irq("timer_irq_o expired", timer_irq, 1'b1);
		write_reg(TIMER_BANK, TMR_STATUS, 32'd1);
		check_irq("timer_irq_o cleared", timer_irq, 1'b0);
		end_test("timer one-shot", errs);

		// Timer auto-reload, interrupt enable off
		errs = n_errors;
		r = rand_word();
		cmp = 32'd8 + 32'(r[3:0]);
		write_reg(TIMER_BANK, TMR_COUNT, 32'd0);
		write_reg(TIMER_BANK, TMR_COMPARE, cmp);
		write_reg(TIMER_BANK, TMR_STATUS, 32'd1);
		write_reg(TIMER_BANK, TMR_CTRL, 32'd3);
		wait_cycles(2 * int'(cmp) + 10);
		read_reg(TIMER_BANK, TMR_STATUS, rd);
		check_word("TMR_STATUS auto-reload", rd, 32'd1);
		read_reg(TIMER_BANK, TMR_CTRL, rd);
		check_word("TMR_CTRL auto-reload", rd, 32'd3);
		check_irq("timer_irq_o masked", timer_irq, 1'b0);
		for (int i = 0; i < 6; i++) begin
			read_reg(TIMER_BANK, TMR_COUNT, rd);
			n_checks++;
			if (rd > cmp) begin
				n_errors++;
				$display("Error at %0t: TMR_COUNT 0x%08h above compare 0x%08h", $time, rd, cmp);
			end
		end
		write_reg(TIMER_BANK, TMR_CTRL, 32'd0);
		write_reg(TIMER_BANK, TMR_STATUS, 32'd1);
		end_test("timer auto-reload", errs);

		// Mixed traffic over both banks
		errs = n_errors;
		for (int j = 0; j < 5; j++) begin
			mix_write(j, rand_word());
		end
		for (int i = 0; i < N_MIX; i++) begin
			r = rand_word();
			k = int'(r[7:0] % 8'd5);
			if (r[8]) begin
				mix_write(k, rand_word());
			end else begin
				read_reg(mix_bank(k), mix_reg(k), rd);
				check_word($sformatf("mixed read of register %0d", k), rd, mix_expect(k));
			end
		end
		for (int j = 0; j < 5; j++) begin
			read_reg(mix_bank(j), mix_reg(j), rd);
			check_word($sformatf("final read of register %0d", j), rd, mix_expect(j));
		end
		end_test("mixed traffic", errs);

		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
src/csr_pkg.sv
src/wb_csr_bridge.sv
src/gpio_ctl.sv
src/timer_ctl.sv
src/periph_top.sv
dv/tb_periph_top.sv

// File: Makefile
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_periph_top
FILELIST  := src.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

# Passes only when the run prints the pass message
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
